/* source/metricPkg.sv */
package metricPkg;

   // received sample straight from the matched filter
   localparam int sampleWidth = 8;

   // branch metrics and accumulators share one width
   // four bits of headroom over the sample
   localparam int metricWidth = sampleWidth + 4;

   // amount taken off both accumulators when one of them runs high
   localparam logic [metricWidth-1:0] normStep = metricWidth'(512);

   // top two accumulator bits, 01 means the positive range is half used
   localparam logic [1:0] normPattern = 2'b01;

endpackage

/* source/trellisPkg.sv */
package trellisPkg;

   // one state per value of the previous bit
   // the encoding doubles as the decided bit, +1 maps to 0 and -1 maps to 1
   typedef enum logic {
      statePlus  = 1'b0, // previous bit was +1
      stateMinus = 1'b1  // previous bit was -1
   } trellisState;

   localparam int numStates = 2;

   // leakage of the previous bit into the current sample, on the sample scale
   localparam logic signed [metricPkg::sampleWidth-1:0] isiTap = 8'sd40;

   // symbols held in each survivor path before a bit is released
   localparam int survivorDepth = 16;

endpackage

/* source/branchMetric.sv */
module branchMetric (
   input  logic                                    clk,
   input  logic                                    reset,
   input  logic signed [metricPkg::sampleWidth-1:0] sample,
   input  logic                                    sampleValid,
   output logic                                    symEn,
   output logic signed [metricPkg::metricWidth-1:0] bmPlusFromPlus,
   output logic signed [metricPkg::metricWidth-1:0] bmPlusFromMinus,
   output logic signed [metricPkg::metricWidth-1:0] bmMinusFromPlus,
   output logic signed [metricPkg::metricWidth-1:0] bmMinusFromMinus
);
   import metricPkg::*;
   import trellisPkg::*;

   logic signed [sampleWidth-1:0] sampleReg; // sample held for the symbol being processed
   logic signed [metricWidth-1:0] sampleExt;
   logic signed [metricWidth-1:0] tapExt;
   logic signed [metricWidth-1:0] rMinusTap; // predecessor was +1
   logic signed [metricWidth-1:0] rPlusTap;  // predecessor was -1

   // strobe and sample move together, so symEn marks valid metrics
   always_ff @(posedge clk) begin
      if (reset) begin
         symEn <= 1'b0;
      end else begin
         symEn <= sampleValid;
      end
   end

   always_ff @(posedge clk) begin
      if (sampleValid) begin
         sampleReg <= sample; // no reset, payload only
      end
   end

   // sign extend into the metric width, worst case |r| + tap still fits
   assign sampleExt = metricWidth'(sampleReg);
   assign tapExt    = metricWidth'(isiTap);

   // strip the expected interference of each possible predecessor
   assign rMinusTap = sampleExt - tapExt;
   assign rPlusTap  = sampleExt + tapExt;

   // correlation with the candidate bit, d * (r - tap * p)
   assign bmPlusFromPlus   = rMinusTap;
   assign bmPlusFromMinus  = rPlusTap;
   assign bmMinusFromPlus  = -rMinusTap;
   assign bmMinusFromMinus = -rPlusTap;

endmodule

/* source/acs.sv */
module acs (
   input  logic                                    clk,
   input  logic                                    reset,
   input  logic                                    symEn,
   input  logic signed [metricPkg::metricWidth-1:0] bmFromPlus,
   input  logic signed [metricPkg::metricWidth-1:0] bmFromMinus,
   input  logic        [metricPkg::metricWidth-1:0] accPlus,
   input  logic        [metricPkg::metricWidth-1:0] accMinus,
   input  logic                                    normalize,
   output logic        [metricPkg::metricWidth-1:0] accMet,
   output trellisPkg::trellisState                  decision,
   output logic                                    overflowWarn
);
   import metricPkg::*;
   import trellisPkg::*;

   // one extra bit so a negative metric on a small accumulator does not wrap
   logic signed [metricWidth:0] sumPlus;
   logic signed [metricWidth:0] sumMinus;
   logic signed [metricWidth:0] winner;
   logic signed [metricWidth:0] trimmed;
   logic        [metricWidth-1:0] nextMet;
   logic                          minusWins;

   // accumulators never go negative, zero extend them before the signed add
   assign sumPlus  = $signed({1'b0, accPlus}) + bmFromPlus;
   assign sumMinus = $signed({1'b0, accMinus}) + bmFromMinus;

   // larger metric survives
   // a tie keeps the path through statePlus
   assign minusWins = (sumMinus > sumPlus);
   assign winner    = minusWins ? sumMinus : sumPlus;

   // early warning, positive and already into the upper half of the range
   assign overflowWarn = ({winner[metricWidth], winner[metricWidth-1 -: 2]} ==
                          {1'b0, normPattern});

   // both units take off the same step, so metric differences are kept
   assign trimmed = normalize ? (winner - $signed({1'b0, normStep})) : winner;

   // anything below zero clamps, the accumulator stays in its positive range
   assign nextMet = trimmed[metricWidth] ? '0 : trimmed[metricWidth-1:0];

   always_ff @(posedge clk) begin
      if (reset) begin
         accMet   <= '0;
         decision <= statePlus;
      end else if (symEn) begin
         accMet   <= nextMet;
         decision <= minusWins ? stateMinus : statePlus; // chosen predecessor
      end
   end

endmodule

/* source/survivorExchange.sv */
module survivorExchange (
   input  logic                             clk,
   input  logic                             reset,
   input  logic                             symEn,
   input  trellisPkg::trellisState          decisionPlus,
   input  trellisPkg::trellisState          decisionMinus,
   input  logic [metricPkg::metricWidth-1:0] accPlus,
   input  logic [metricPkg::metricWidth-1:0] accMinus,
   output logic                             bitOut,
   output logic                             bitValid
);
   import metricPkg::*;
   import trellisPkg::*;

   logic                                  symEnDly; // decisions settle one cycle after symEn
   trellisState                           pred [numStates];
   logic [survivorDepth-1:0]              path [numStates];     // newest bit at the lsb
   logic [survivorDepth-1:0]              nextPath [numStates];
   trellisState                           bestState;
   logic [$clog2(survivorDepth)-1:0]      fillCount;
   logic                                  pathsFull;

   // predecessor table indexed by the state it leads into
   assign pred[statePlus]  = decisionPlus;
   assign pred[stateMinus] = decisionMinus;

   // each state inherits its predecessor's history
   // then appends its own bit value
   always_comb begin
      for (int s = 0; s < numStates; s++) begin
         nextPath[s] = {path[pred[s]][survivorDepth-2:0], 1'(s)};
      end
   end

   // accumulators already hold this symbol's update, same as the decisions
   // tie goes to statePlus as in the ACS
   assign bestState = (accMinus > accPlus) ? stateMinus : statePlus;

   // first survivorDepth-1 symbols only prime the paths
   assign pathsFull = (int'(fillCount) == survivorDepth - 1);

   always_ff @(posedge clk) begin
      if (reset) begin
         symEnDly  <= 1'b0;
      end else begin
         symEnDly  <= symEn;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         fillCount <= '0;
         bitValid  <= 1'b0;
         bitOut    <= 1'b0;
         for (int s = 0; s < numStates; s++) begin
            path[s] <= '0;
         end
      end else begin
         bitValid <= symEnDly && pathsFull; // one pulse per symbol once primed
         if (symEnDly) begin
            for (int s = 0; s < numStates; s++) begin
               path[s] <= nextPath[s];
            end
            bitOut <= nextPath[bestState][survivorDepth-1]; // oldest bit of best path
            if (!pathsFull) begin
               fillCount <= fillCount + 1'b1; // saturates at depth - 1
            end
         end
      end
   end

endmodule

/* source/mlseDetector.sv */
module mlseDetector (
   input  logic                                    clk,
   input  logic                                    reset,
   input  logic signed [metricPkg::sampleWidth-1:0] sample,
   input  logic                                    sampleValid,
   output logic                                    bitOut,
   output logic                                    bitValid
);
   import metricPkg::*;
   import trellisPkg::*;

   logic                          symEn;
   logic signed [metricWidth-1:0] bmPlusFromPlus;
   logic signed [metricWidth-1:0] bmPlusFromMinus;
   logic signed [metricWidth-1:0] bmMinusFromPlus;
   logic signed [metricWidth-1:0] bmMinusFromMinus;
   logic        [metricWidth-1:0] accMetPlus;
   logic        [metricWidth-1:0] accMetMinus;
   trellisState                   decisionPlus;
   trellisState                   decisionMinus;
   logic                          warnPlus;
   logic                          warnMinus;
   logic                          normalize;

   // either accumulator running high pulls both down together
   assign normalize = warnPlus | warnMinus;

   branchMetric bmStage (
      .clk(clk), .reset(reset),
      .sample(sample), .sampleValid(sampleValid),
      .symEn(symEn),
      .bmPlusFromPlus(bmPlusFromPlus), .bmPlusFromMinus(bmPlusFromMinus),
      .bmMinusFromPlus(bmMinusFromPlus), .bmMinusFromMinus(bmMinusFromMinus)
   );

   // state +1, both branches ending in a +1 bit
   acs acsPlus (
      .clk(clk), .reset(reset), .symEn(symEn),
      .bmFromPlus(bmPlusFromPlus), .bmFromMinus(bmPlusFromMinus),
      .accPlus(accMetPlus), .accMinus(accMetMinus), .normalize(normalize),
      .accMet(accMetPlus), .decision(decisionPlus), .overflowWarn(warnPlus)
   );

   // state -1
   acs acsMinus (
      .clk(clk), .reset(reset), .symEn(symEn),
      .bmFromPlus(bmMinusFromPlus), .bmFromMinus(bmMinusFromMinus),
      .accPlus(accMetPlus), .accMinus(accMetMinus), .normalize(normalize),
      .accMet(accMetMinus), .decision(decisionMinus), .overflowWarn(warnMinus)
   );

   survivorExchange survivor (
      .clk(clk), .reset(reset), .symEn(symEn),
      .decisionPlus(decisionPlus), .decisionMinus(decisionMinus),
      .accPlus(accMetPlus), .accMinus(accMetMinus),
      .bitOut(bitOut), .bitValid(bitValid)
   );

endmodule

/* sim/mlseDetector_chk.sv */
module mlseDetector_chk (
   input logic                             clk,
   input logic                             reset,
   input logic                             sampleValid,
   input logic                             bitValid,
   input logic                             symEn,
   input logic [metricPkg::metricWidth-1:0] accMetPlus,
   input logic [metricPkg::metricWidth-1:0] accMetMinus,
   input logic                             decisionPlus,
   input logic                             decisionMinus
);
   import metricPkg::*;

   // pipeline is three deep, nothing can come out right after reset
   quietAfterReset: assert property (@(posedge clk)
      ($past(reset) || $past(reset, 2) || $past(reset, 3)) |-> !bitValid)
      else $error("bitValid high within 3 cycles of reset");

   // every decided bit belongs to a strobe exactly three cycles back
   bitFollowsSample: assert property (@(posedge clk) disable iff (reset)
      bitValid |-> $past(sampleValid, 3))
      else $error("bitValid without sampleValid 3 cycles earlier");

   // ACS state only moves on a symbol
   acsHoldsIdle: assert property (@(posedge clk) disable iff (reset)
      !symEn |=> ($stable(accMetPlus) && $stable(accMetMinus) &&
                  $stable(decisionPlus) && $stable(decisionMinus)))
      else $error("ACS state changed while symEn low");

   // normalization keeps both accumulators in the lower half
   noMetricOverflow: assert property (@(posedge clk) disable iff (reset)
      !accMetPlus[metricWidth-1] && !accMetMinus[metricWidth-1])
      else $error("accumulated metric reached the top bit");

endmodule

bind mlseDetector mlseDetector_chk chk (
   .clk(clk), .reset(reset), .sampleValid(sampleValid), .bitValid(bitValid),
   .symEn(symEn), .accMetPlus(accMetPlus), .accMetMinus(accMetMinus),
   .decisionPlus(decisionPlus), .decisionMinus(decisionMinus)
);

/* sim/mlseDetectorTb.sv */
module mlseDetectorTb;
   import metricPkg::*;

   localparam int numLines     = 64;
   localparam int primeCount   = 15;               // samples that only fill the paths
   localparam int expectedBits = numLines - primeCount;
   localparam int waitLimit    = 200;

   logic                          clk = 1'b0; // low before any process starts, no edge at time 0
   logic                          reset;
   logic signed [sampleWidth-1:0] sample;
   logic                          sampleValid;
   logic                          bitOut;
   logic                          bitValid;

   logic [7:0] stimMem [0:2*numLines-1]; // sample then expected bit, per line
   bit         bitsSeen [$];
   bit         gappedBits [$];
   int         testsPassed;
   int         testsFailed;
   int         normCount;  // symbols on which both accumulators were pulled down
   int         resetBits;  // bitValid seen while reset high
   int         quietBits;  // bits seen before the paths are full

   mlseDetector uut (
      .clk(clk), .reset(reset),
      .sample(sample), .sampleValid(sampleValid),
      .bitOut(bitOut), .bitValid(bitValid)
   );

   initial begin
      forever #5 clk = ~clk;
   end

   // outputs are registered, so the falling edge sees them settled
   always @(negedge clk) begin
      if (bitValid) begin
         if (reset) begin
            resetBits++;
         end else begin
            bitsSeen.push_back(bitOut);
         end
      end
      if (!reset && uut.symEn && uut.normalize) begin
         normCount++;
      end
   end

   function automatic bit expectedBit(input int sym);
      return stimMem[2*(sym+primeCount)+1][0]; // symbol k decided at line k+15
   endfunction

   task automatic idleCycles(input int n);
      repeat (n) @(negedge clk);
   endtask

   task automatic applyReset;
      reset       = 1'b1;
      sampleValid = 1'b0;
      idleCycles(2);
      reset = 1'b0;
   endtask

   // missing bits are caught again by the count and decoding checks
   task automatic waitForBits;
      int cycles;
      cycles = 0;
      while (bitsSeen.size() < expectedBits && cycles < waitLimit) begin
         @(negedge clk);
         cycles++;
      end
      if (bitsSeen.size() < expectedBits) begin
         $display("timeout: only %0d of %0d decided bits arrived",
                  bitsSeen.size(), expectedBits);
      end
   endtask

   task automatic drivePass(input bit withGaps);
      int gap;
      applyReset();
      bitsSeen.delete();
      for (int k = 0; k < numLines; k++) begin
         sample      = stimMem[2*k];
         sampleValid = 1'b1;
         @(negedge clk);
         sampleValid = 1'b0;
         if (withGaps && k == primeCount - 1) begin
            idleCycles(4); // let the pipeline empty before the first real bit
            quietBits = bitsSeen.size();
         end else if (withGaps) begin
            gap = $urandom_range(3, 0);
            idleCycles(gap);
         end
      end
      waitForBits();
      idleCycles(10); // any extra bit would show up here
   endtask

   // compares decided bits of symbols first..last with the file
   task automatic checkRange(input int first, input int last, output int errs);
      errs = 0;
      for (int i = first; i <= last; i++) begin
         if (i >= bitsSeen.size()) begin
            $display("decided bit for symbol %0d never arrived", i);
            errs++;
         end else if (bitsSeen[i] != expectedBit(i)) begin
            $display("FAIL bitOut symbol %0d expected %h got %h",
                     i, expectedBit(i), bitsSeen[i]);
            errs++;
         end
      end
   endtask

   task automatic reportTest(input string name, input int errs);
      if (errs == 0) begin
         testsPassed++;
         $display("test %s: ok", name);
      end else begin
         testsFailed++;
         $display("test %s: %0d errors", name, errs);
      end
   endtask

   initial begin
      int errs;
      void'($urandom(27));
      reset       = 1'b1;
      sample      = '0;
      sampleValid = 1'b0;
      testsPassed = 0;
      testsFailed = 0;
      normCount   = 0;
      resetBits   = 0;
      quietBits   = 0;
      $readmemh("sim/mlse_stim.txt", stimMem);

      drivePass(1'b1);

      errs = 0;
      if (resetBits != 0) begin
         $display("bitValid pulsed %0d times during reset", resetBits);
         errs++;
      end
      if (quietBits != 0) begin
         $display("bitValid pulsed %0d times before the paths were full", quietBits);
         errs++;
      end
      reportTest("reset quiet", errs);

      errs = 0;
      if (bitsSeen.size() != expectedBits) begin
         $display("FAIL bitCount expected %h got %h", expectedBits, bitsSeen.size());
         errs++;
      end
      reportTest("bit count", errs);

      checkRange(0, expectedBits - 1, errs);
      reportTest("decoding", errs);

      checkRange(16, 31, errs); // alternating bits, samples near zero
      reportTest("interference resolution", errs);

      checkRange(32, expectedBits - 1, errs); // full scale runs
      if (normCount < 2) begin
         $display("metrics normalized only %0d times", normCount);
         errs++;
      end
      reportTest("normalization", errs);

      gappedBits = bitsSeen;
      drivePass(1'b0);
      checkRange(0, expectedBits - 1, errs);
      if (bitsSeen.size() != gappedBits.size()) begin
         $display("FAIL bitCount expected %h got %h", gappedBits.size(), bitsSeen.size());
         errs++;
      end
      reportTest("back-to-back", errs);

      $display("tests passed %0d failed %0d", testsPassed, testsFailed);
      if (testsFailed == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

/* build.f */
source/metricPkg.sv
source/trellisPkg.sv
source/branchMetric.sv
source/acs.sv
source/survivorExchange.sv
source/mlseDetector.sv
sim/mlseDetector_chk.sv
sim/mlseDetectorTb.sv

/* Makefile */
# Verilator build of the MLSE detector testbench

SOURCES := $(shell cat build.f)

.PHONY: all run clean

all: obj_dir/VmlseDetectorTb

obj_dir/VmlseDetectorTb: build.f $(SOURCES)
	verilator --binary --assert --top-module mlseDetectorTb \
		-f build.f -Mdir obj_dir -o VmlseDetectorTb

run: obj_dir/VmlseDetectorTb
	./obj_dir/VmlseDetectorTb | tee sim.log
	grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

/* sim/mlse_stim.txt */
// sample (hex, signed 8 bit)  expected decided bit (x while paths fill)
// bit on line k is the decision for symbol k-15, 0 is +1 and 1 is -1
6E x
6E x
E2 x
1E x
E2 x
92 x
1E x
6E x
E2 x
92 x
92 x
1E x
E2 x
1E x
6E x
E2 0
08 0
F8 1
08 0
F8 1
08 1
F8 0
08 0
F8 1
08 1
F8 1
08 0
F8 1
08 0
F8 0
08 1
F8 0
2F 1
7F 0
7F 1
7F 0
7F 1
7F 0
7F 1
7F 0
D1 1
81 0
81 1
81 0
81 1
81 0
81 1
81 0
9C 0
14 0
64 0
EC 0
14 0
EC 0
9C 0
9C 1
14 1
64 1
EC 1
14 1
EC 1
9C 1
14 1
64 1
